// ==== tb.f ====
design/memset_pkg.sv
design/single_port_ram.sv
design/memory_controller.sv
design/fill_counter.sv
design/memset_ctrl.sv
design/memset_top.sv
dv/memset_checker.sv
dv/tb_memset.sv

// ==== Bender.yml ====
package:
  name: memset

sources:
  - design/memset_pkg.sv
  - design/single_port_ram.sv
  - design/memory_controller.sv
  - design/fill_counter.sv
  - design/memset_ctrl.sv
  - design/memset_top.sv
  - target: simulation
    files:
      - dv/memset_checker.sv
      - dv/tb_memset.sv

// ==== dv/tb_memset.sv ====
`timescale 1ns/1ns

module tb_memset;

	localparam int ADDR_WIDTH = memset_pkg::MEM_ADDR_WIDTH_DEFAULT;
	localparam int DATA_WIDTH = memset_pkg::MEM_DATA_WIDTH_DEFAULT;
	localparam int DEPTH      = 1 << ADDR_WIDTH;
	localparam int NUM_ROWS   = 8;

	logic                  clk;
	logic                  reset;
	logic                  start;
	memset_pkg::word_t     m;
	memset_pkg::word_t     c;
	memset_pkg::word_t     n;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic                  finish;
	logic                  busy;
	memset_pkg::word_t     return_val;
	logic [DATA_WIDTH-1:0] rd_data;

	// Stimulus table. fin_edge is the edge at which finish must be seen,
	// counting the edge that samples start as edge 1.
	memset_pkg::word_t tbl_m     [NUM_ROWS];
	memset_pkg::word_t tbl_c     [NUM_ROWS];
	memset_pkg::word_t tbl_n     [NUM_ROWS];
	int                tbl_fin   [NUM_ROWS];
	bit                tbl_extra [NUM_ROWS];

	logic [DATA_WIDTH-1:0] model [DEPTH];

	int          check_count = 0;
	int          error_count = 0;
	int          cycle_count = 0;
	int          timeout_limit = 0;

	memset_top
	#(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	)
	i_memset_top
	(
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.m         (m),
		.c         (c),
		.n         (n),
		.rd_addr   (rd_addr),
		.finish    (finish),
		.busy      (busy),
		.return_val(return_val),
		.rd_data   (rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Error: %s is 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic set_row(input int r, input memset_pkg::word_t rm, input memset_pkg::word_t rc,
		input memset_pkg::word_t rn, input int fin, input bit extra);
		tbl_m[r]     = rm;
		tbl_c[r]     = rc;
		tbl_n[r]     = rn;
		tbl_fin[r]   = fin;
		tbl_extra[r] = extra;
	endtask

	task automatic load_table();
		// Row 0 clears the whole RAM so that the model is known from then on.
		set_row(0, 32'h0000_0000, 32'h0000_0000, 32'd32, 35, 1'b0);
		set_row(1, 32'h0000_0004, 32'h0000_01a5, 32'd6, 9, 1'b0);
		// Starts at word 28 and runs more than once round the RAM.
		set_row(2, 32'h0000_003c, 32'h0000_005a, 32'd40, 43, 1'b0);
		set_row(3, 32'h0000_000a, 32'h0000_0077, 32'd0, 3, 1'b0);
		set_row(4, 32'h0000_0011, 32'hdead_be42, 32'd5, 8, 1'b1);
		set_row(5, 32'h0000_001f, 32'h0000_0081, 32'd2, 5, 1'b0);
		set_row(6, 32'h0000_1008, 32'h0000_00ff, 32'd1, 4, 1'b0);
		set_row(7, 32'h0000_0014, 32'h0000_000f, 32'd9, 12, 1'b0);
	endtask

	// Called right after a falling edge. Returns right after a falling edge.
	task automatic run_job(input memset_pkg::word_t jm, input memset_pkg::word_t jc,
		input memset_pkg::word_t jn, input int fin_edge, input bit extra);
		int          edge_cnt;
		int          extra_edge;
		bit          seen;
		int unsigned pick;
		extra_edge = -1;
		if (extra)
		begin
			pick       = $urandom % (fin_edge - 1);
			extra_edge = 2 + int'(pick);
		end
		m        = jm;
		c        = jc;
		n        = jn;
		start    = 1'b1;
		edge_cnt = 1;
		seen     = 1'b0;
		@(posedge clk);
		@(negedge clk);
		start = 1'b0;
		while (!seen)
		begin
			@(posedge clk);
			@(negedge clk);
			edge_cnt++;
			// A second start lands somewhere inside the job and must be ignored.
			start = (edge_cnt == extra_edge);
			check_value("busy", busy, 1'b1);
			if (finish)
			begin
				seen = 1'b1;
				check_value("finish edge", edge_cnt, fin_edge);
				check_value("return_val", return_val, jm);
			end
		end
		@(posedge clk);
		@(negedge clk);
		start = 1'b0;
		check_value("finish", finish, 1'b0);
		check_value("busy", busy, 1'b0);
		check_value("return_val", return_val, jm);
	endtask

	task automatic update_model(input memset_pkg::word_t jm, input memset_pkg::word_t jc,
		input memset_pkg::word_t jn);
		longint unsigned i;
		longint unsigned base;
		longint unsigned idx;
		base = jm;
		for (i = 0; i < jn; i++)
		begin
			idx        = (base + i) % DEPTH;
			model[idx] = jc[DATA_WIDTH-1:0];
		end
	endtask

	// Reads every word while the engine is idle. The data for an address
	// comes back one cycle after the address is presented.
	task automatic read_back();
		int a;
		rd_addr = '0;
		for (a = 0; a < DEPTH; a++)
		begin
			@(posedge clk);
			@(negedge clk);
			check_value($sformatf("rd_data[%0d]", a), rd_data, model[a]);
			if (a + 1 < DEPTH)
			begin
				rd_addr = ADDR_WIDTH'(a + 1);
			end
		end
	endtask

	initial
	begin
		while ((timeout_limit == 0) || (cycle_count < timeout_limit))
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not complete within %0d clock cycles.", timeout_limit);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		int r;
		int a;
		int total_errors;
		void'($urandom(2623));
		reset    = 1'b1;
		start    = 1'b0;
		m        = '0;
		c        = '0;
		n        = '0;
		rd_addr  = '0;
		load_table();
		timeout_limit = 50;
		for (r = 0; r < NUM_ROWS; r++)
		begin
			timeout_limit += int'(tbl_n[r]) + 4 + DEPTH + 2;
		end
		for (a = 0; a < DEPTH; a++)
		begin
			model[a] = '0;
		end

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("busy", busy, 1'b0);
		check_value("finish", finish, 1'b0);
		check_value("return_val", return_val, 32'h0);

		for (r = 0; r < NUM_ROWS; r++)
		begin
			run_job(tbl_m[r], tbl_c[r], tbl_n[r], tbl_fin[r], tbl_extra[r]);
			update_model(tbl_m[r], tbl_c[r], tbl_n[r]);
			read_back();
		end

		total_errors = error_count + i_memset_top.i_memset_ctrl.i_memset_checker.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
			i_memset_top.i_memset_ctrl.i_memset_checker.fail_count);
		if (total_errors == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/memset_checker.sv ====
`timescale 1ns/1ns

module memset_checker
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic wr_en,
	input logic busy,
	input logic finish
);

	// Number of assertion failures, read by the testbench at the end of the run.
	int unsigned fail_count = 0;

	// finish only ever lasts one cycle.
	finish_single_cycle: assert property (@(posedge clk) disable iff (reset) finish |=> !finish)
	else
	begin
		$error("finish stayed high for two consecutive cycles");
		fail_count++;
	end

	// A RAM write can only happen while a job owns the port.
	write_while_busy: assert property (@(posedge clk) disable iff (reset) wr_en |-> busy)
	else
	begin
		$error("wr_en was high while busy was low");
		fail_count++;
	end

	// The counter is loaded in SETUP, never in a write cycle.
	no_write_on_load: assert property (@(posedge clk) disable iff (reset) load |-> !wr_en)
	else
	begin
		$error("wr_en was high in the same cycle as load");
		fail_count++;
	end

	idle_after_reset: assert property (@(posedge clk) reset |=> (!finish && !busy))
	else
	begin
		$error("finish or busy was high right after reset");
		fail_count++;
	end

endmodule

bind memset_ctrl memset_checker i_memset_checker
(
	.clk   (clk),
	.reset (reset),
	.load  (load),
	.wr_en (wr_en),
	.busy  (busy),
	.finish(finish)
);

// ==== design/memset_top.sv ====
`timescale 1ns/1ns

module memset_top
#(
	parameter int ADDR_WIDTH = memset_pkg::MEM_ADDR_WIDTH_DEFAULT,
	parameter int DATA_WIDTH = memset_pkg::MEM_DATA_WIDTH_DEFAULT
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  memset_pkg::word_t     m,
	input  memset_pkg::word_t     c,
	input  memset_pkg::word_t     n,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output logic                  finish,
	output logic                  busy,
	output memset_pkg::word_t     return_val,
	output logic [DATA_WIDTH-1:0] rd_data
);

	logic                  load;
	logic                  wr_en;
	logic                  last;
	logic                  empty;
	logic [ADDR_WIDTH-1:0] wr_addr;

	// Sequencing of the job.
	memset_ctrl i_memset_ctrl
	(
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.empty     (empty),
		.last      (last),
		.m         (m),
		.load      (load),
		.wr_en     (wr_en),
		.busy      (busy),
		.finish    (finish),
		.return_val(return_val)
	);

	// Walks the address and counts the words still to write.
	fill_counter
	#(
		.ADDR_WIDTH(ADDR_WIDTH)
	)
	i_fill_counter
	(
		.clk    (clk),
		.reset  (reset),
		.load   (load),
		.wr_en  (wr_en),
		.m      (m),
		.n      (n),
		.wr_addr(wr_addr),
		.last   (last),
		.empty  (empty)
	);

	// The RAM, shared between engine writes and host reads.
	memory_controller
	#(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	)
	i_memory_controller
	(
		.clk    (clk),
		.busy   (busy),
		.wr_en  (wr_en),
		.wr_addr(wr_addr),
		.c      (c),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

// ==== design/memset_ctrl.sv ====
`timescale 1ns/1ns

module memset_ctrl
(
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  logic              empty,
	input  logic              last,
	input  memset_pkg::word_t m,
	output logic              load,
	output logic              wr_en,
	output logic              busy,
	output logic              finish,
	output memset_pkg::word_t return_val
);

	memset_pkg::ctrl_state_e state_q;
	memset_pkg::ctrl_state_e state_d;

	// Set by the final write of a job.
	// Once it is set, FILL has nothing left to write.
	logic fill_done_q;

	// Next state.
	// A start pulse is only looked at in IDLE, so a second start that
	// arrives while a job runs has no effect.
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			memset_pkg::IDLE:
			begin
				if (start)
				begin
					state_d = memset_pkg::SETUP;
				end
			end
			memset_pkg::SETUP:
			begin
				state_d = memset_pkg::FILL;
			end
			memset_pkg::FILL:
			begin
				// A zero count shows up as empty right after the load.
				// Otherwise the cycle after the last write ends the fill.
				if (fill_done_q || empty)
				begin
					state_d = memset_pkg::DONE;
				end
			end
			memset_pkg::DONE:
			begin
				state_d = memset_pkg::IDLE;
			end
			default:
			begin
				state_d = memset_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q     <= memset_pkg::IDLE;
			fill_done_q <= 1'b0;
			return_val  <= '0;
		end
		else
		begin
			state_q <= state_d;

			if (load)
			begin
				fill_done_q <= 1'b0;
			end
			else if (wr_en && last)
			begin
				fill_done_q <= 1'b1;
			end

			// The result is taken as DONE is entered.
			// It then holds until the end of the next job.
			if ((state_q == memset_pkg::FILL) && (state_d == memset_pkg::DONE))
			begin
				return_val <= m;
			end
		end
	end

	// The control outputs are plain decodes of the state register.
	always_comb
	begin
		load   = (state_q == memset_pkg::SETUP);
		wr_en  = (state_q == memset_pkg::FILL) && !empty && !fill_done_q;
		busy   = (state_q != memset_pkg::IDLE);
		finish = (state_q == memset_pkg::DONE);
	end

endmodule

// ==== design/fill_counter.sv ====
`timescale 1ns/1ns

module fill_counter
#(
	parameter int ADDR_WIDTH = 5
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  load,
	input  logic                  wr_en,
	input  memset_pkg::word_t     m,
	input  memset_pkg::word_t     n,
	output logic [ADDR_WIDTH-1:0] wr_addr,
	output logic                  last,
	output logic                  empty
);

	logic [ADDR_WIDTH-1:0] addr_q;
	memset_pkg::word_t     count_q;

	// The address is kept as narrow as the RAM itself.
	// Stepping past the top word then rolls over to word 0 by itself,
	// which is the wrap the fill needs.
	// The count stays a full word, so a count larger than the RAM simply
	// goes round again and writes the same value over the same words.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			addr_q  <= '0;
			count_q <= '0;
		end
		else if (load)
		begin
			addr_q  <= m[ADDR_WIDTH-1:0];
			count_q <= n;
		end
		else if (wr_en)
		begin
			addr_q  <= addr_q + 1'b1;
			count_q <= count_q - 1'b1;
		end
	end

	assign wr_addr = addr_q;

	// Both flags are decoded from the count register.
	// They carry no extra state and are valid from the first cycle of FILL.
	always_comb
	begin
		empty = (count_q == '0);
		last  = (count_q <= memset_pkg::word_t'(1));
	end

endmodule

// ==== design/memory_controller.sv ====
`timescale 1ns/1ns

module memory_controller
#(
	parameter int ADDR_WIDTH = 5,
	parameter int DATA_WIDTH = 8
)
(
	input  logic                  clk,
	input  logic                  busy,
	input  logic                  wr_en,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  memset_pkg::word_t     c,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data
);

	logic [ADDR_WIDTH-1:0] ram_addr;
	logic                  ram_we;
	logic [DATA_WIDTH-1:0] ram_data;
	logic [DATA_WIDTH-1:0] ram_out;

	// The RAM has one port, so the engine and the host take turns on it.
	// The engine owns the port for the whole job.
	// The host only gets it back once the engine is idle again.
	always_comb
	begin
		if (busy)
		begin
			ram_addr = wr_addr;
			ram_we   = wr_en;
		end
		else
		begin
			ram_addr = rd_addr;
			ram_we   = 1'b0;
		end
	end

	// The fill value arrives as a full word.
	// Only its low bits fit into a RAM word; the rest is dropped here.
	assign ram_data = c[DATA_WIDTH-1:0];

	single_port_ram
	#(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	)
	i_single_port_ram
	(
		.clk (clk),
		.addr(ram_addr),
		.we  (ram_we),
		.data(ram_data),
		.out (ram_out)
	);

	// The read data is already registered inside the RAM.
	// It shows up one cycle after the host presents rd_addr.
	assign rd_data = ram_out;

endmodule

// ==== design/single_port_ram.sv ====
`timescale 1ns/1ns

module single_port_ram
#(
	parameter int ADDR_WIDTH = 5,
	parameter int DATA_WIDTH = 8
)
(
	input  logic                  clk,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic                  we,
	input  logic [DATA_WIDTH-1:0] data,
	output logic [DATA_WIDTH-1:0] out
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// The write and the read share the one address.
	// The read register samples the array before the write lands, so a
	// write cycle returns the word that was there before it.
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[addr] <= data;
		end
		out <= mem[addr];
	end

endmodule

// ==== design/memset_pkg.sv ====
package memset_pkg;

	// Every scalar on the host side of the engine is one 32-bit word.
	// That covers the base address, the fill value, the count and the result.
	typedef logic [31:0] word_t;

	// Control states of the fill engine.
	// SETUP loads the counter, FILL writes one word per cycle and DONE
	// is the single cycle in which finish is high.
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		SETUP = 2'd1,
		FILL  = 2'd2,
		DONE  = 2'd3
	} ctrl_state_e;

	// The on-chip RAM defaults to 32 words of one byte.
	localparam int MEM_ADDR_WIDTH_DEFAULT = 5;
	localparam int MEM_DATA_WIDTH_DEFAULT = 8;

endpackage
